// File: logic/pool_pkg.sv
package pool_pkg;

	//////////////////////////////////////////////////
	// Image geometry
	//////////////////////////////////////////////////

	// Pixels per row and rows per frame
	localparam int IMAGE_WIDTH  = 8;
	localparam int IMAGE_HEIGHT = 8;

	// Bits per pixel
	localparam int PIXEL_WIDTH = 16;

	// Index widths for column and row counters
	localparam int COL_WIDTH = 3;
	localparam int ROW_WIDTH = 3;

	// Last index on each axis, used for counter wrap
	localparam logic [COL_WIDTH-1:0] LAST_COL = COL_WIDTH'(IMAGE_WIDTH - 1);
	localparam logic [ROW_WIDTH-1:0] LAST_ROW = ROW_WIDTH'(IMAGE_HEIGHT - 1);

	//////////////////////////////////////////////////
	// Shared types
	//////////////////////////////////////////////////

	// Signed feature-map pixel
	typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;

	// Position of the pixel currently on the input
	typedef struct packed {
		// Column of the current pixel
		logic [COL_WIDTH-1:0] col;
		// Odd column and odd row, closes a 2x2 window
		logic                 window_end;
	} pixel_pos_t;

	// 2x2 window ending at the current pixel
	typedef struct packed {
		pixel_t top_left;
		pixel_t top_right;
		pixel_t bottom_left;
		pixel_t bottom_right;
	} pool_window_t;

endpackage

// File: logic/pixel_position_tracker.sv
`timescale 1ns/10ps

module pixel_position_tracker (
	input  logic                clk,
	input  logic                reset,
	input  logic                valid_in,
	output pool_pkg::pixel_pos_t pos
);

	import pool_pkg::*;

	//////////////////////////////////////////////////
	// Raster counters
	//////////////////////////////////////////////////

	logic [COL_WIDTH-1:0] col;
	logic [ROW_WIDTH-1:0] row;

	// End of row and end of frame for the pixel on the input
	logic row_last;
	logic frame_last;

	assign row_last   = (col == LAST_COL);
	assign frame_last = row_last && (row == LAST_ROW);

	// Column steps on every accepted pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
		end else if (valid_in) begin
			if (row_last) begin
				col <= '0;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Row steps when the column wraps
	always_ff @(posedge clk) begin
		if (reset) begin
			row <= '0;
		end else if (valid_in && row_last) begin
			if (frame_last) begin
				// Next frame follows back to back
				row <= '0;
			end else begin
				row <= row + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Position flags
	//////////////////////////////////////////////////

	// Bottom right corner of a window sits at odd column, odd row
	always_comb begin
		pos.col        = col;
		pos.window_end = col[0] & row[0];
	end

endmodule

// File: logic/pool_window_buffer.sv
`timescale 1ns/10ps

module pool_window_buffer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  pool_pkg::pixel_t      pxl_in,
	input  pool_pkg::pixel_pos_t  pos,
	output pool_pkg::pool_window_t window
);

	import pool_pkg::*;

	//////////////////////////////////////////////////
	// Line memory
	//////////////////////////////////////////////////

	// One row of pixels, indexed by column
	pixel_t line_mem [IMAGE_WIDTH];

	// Read addresses for the upper half of the window
	logic [COL_WIDTH-1:0] addr_right;
	logic [COL_WIDTH-1:0] addr_left;

	assign addr_right = pos.col;
	assign addr_left  = COL_WIDTH'(pos.col - 1'b1);

	// Previous pixel goes in one column behind the current one,
	// so column col-1 keeps the previous row until this pixel is read
	always_ff @(posedge clk) begin
		if (valid_in) begin
			line_mem[addr_left] <= prev_pixel;
		end
	end

	// Entries still hold the previous row during the read
	pixel_t top_left_pxl;
	pixel_t top_right_pxl;

	assign top_left_pxl  = line_mem[addr_left];
	assign top_right_pxl = line_mem[addr_right];

	//////////////////////////////////////////////////
	// Previous pixel
	//////////////////////////////////////////////////

	pixel_t prev_pixel;

	// Last accepted pixel, left neighbour of the current one
	always_ff @(posedge clk) begin
		if (reset) begin
			prev_pixel <= '0;
		end else if (valid_in) begin
			prev_pixel <= pxl_in;
		end
	end

	//////////////////////////////////////////////////
	// Window assembly
	//////////////////////////////////////////////////

	// Meaningful only when pos.window_end is high
	always_comb begin
		window.top_left     = top_left_pxl;
		window.top_right    = top_right_pxl;
		window.bottom_left  = prev_pixel;
		window.bottom_right = pxl_in;
	end

endmodule

// File: logic/stride2_output_align.sv
`timescale 1ns/10ps

module stride2_output_align (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stride2,
	input  logic                   valid_in,
	input  pool_pkg::pixel_t       pxl_in,
	input  pool_pkg::pixel_pos_t   pos,
	input  pool_pkg::pool_window_t window,
	output logic                   valid_out,
	output pool_pkg::pixel_t       pxl_out
);

	import pool_pkg::*;

	// Signed maximum of two pixels
	function automatic pixel_t max2(input pixel_t a, input pixel_t b);
		pixel_t result;
		if (a > b) begin
			result = a;
		end else begin
			result = b;
		end
		return result;
	endfunction

	//////////////////////////////////////////////////
	// Comparison tree
	//////////////////////////////////////////////////

	// First level, one compare per window row
	pixel_t max_top;
	pixel_t max_bottom;

	assign max_top    = max2(window.top_left, window.top_right);
	assign max_bottom = max2(window.bottom_left, window.bottom_right);

	// Second level
	pixel_t window_max;

	assign window_max = max2(max_top, max_bottom);

	//////////////////////////////////////////////////
	// Mode select
	//////////////////////////////////////////////////

	logic   sel_valid;
	pixel_t sel_pixel;

	always_comb begin
		if (stride2) begin
			// One output per closed window
			sel_valid = valid_in & pos.window_end;
			sel_pixel = window_max;
		end else begin
			// Bypass path
			sel_valid = valid_in;
			sel_pixel = pxl_in;
		end
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= sel_valid;
		end
	end

	// Pixel holds its last value between strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			pxl_out <= '0;
		end else if (sel_valid) begin
			pxl_out <= sel_pixel;
		end
	end

endmodule

// File: logic/conv_pool_stride_top.sv
`timescale 1ns/10ps

module conv_pool_stride_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             stride2,
	input  logic             valid_in,
	input  pool_pkg::pixel_t pxl_in,
	output logic             valid_out,
	output pool_pkg::pixel_t pxl_out
);

	import pool_pkg::*;

	//////////////////////////////////////////////////
	// Internal connections
	//////////////////////////////////////////////////

	// Position of the pixel on pxl_in
	pixel_pos_t   pos;
	// Window ending at that pixel
	pool_window_t window;

	// Raster position and window flag
	pixel_position_tracker pixel_position_tracker_i (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pos      (pos)
	);

	// Line memory and previous pixel
	pool_window_buffer pool_window_buffer_i (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pxl_in   (pxl_in),
		.pos      (pos),
		.window   (window)
	);

	// Max pooling or bypass, registered
	stride2_output_align stride2_output_align_i (
		.clk       (clk),
		.reset     (reset),
		.stride2   (stride2),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.pos       (pos),
		.window    (window),
		.valid_out (valid_out),
		.pxl_out   (pxl_out)
	);

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 4 ns clock period
	localparam int HALF_PERIOD  = 2;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset drops on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: verification/conv_pool_stride_assert.sv
`timescale 1ns/10ps

module conv_pool_stride_assert (
	input logic             clk,
	input logic             reset,
	input logic             valid_in,
	input logic             valid_out,
	input pool_pkg::pixel_t pxl_out
);

	// Read by the testbench at the end of the run
	int failure_count = 0;

	// Output strobe register is cleared by reset
	property reset_clears_valid;
		@(posedge clk) reset |=> !valid_out;
	endproperty

	// One cycle of latency in both modes
	property valid_follows_input;
		@(posedge clk) disable iff (reset) valid_out |-> $past(valid_in);
	endproperty

	property pixel_known;
		@(posedge clk) disable iff (reset) valid_out |-> !$isunknown(pxl_out);
	endproperty

	reset_clears_valid_a: assert property (reset_clears_valid)
		else begin
			$error("valid_out high in the cycle after reset");
			failure_count++;
		end

	valid_follows_input_a: assert property (valid_follows_input)
		else begin
			$error("valid_out without valid_in one cycle earlier");
			failure_count++;
		end

	pixel_known_a: assert property (pixel_known)
		else begin
			$error("pxl_out has unknown bits while valid_out is high");
			failure_count++;
		end

endmodule

bind conv_pool_stride_top conv_pool_stride_assert conv_pool_stride_assert_i (
	.clk       (clk),
	.reset     (reset),
	.valid_in  (valid_in),
	.valid_out (valid_out),
	.pxl_out   (pxl_out)
);

// File: verification/conv_pool_stride_tb.sv
`timescale 1ns/10ps

module conv_pool_stride_tb;

	import pool_pkg::*;

	localparam int          TIMEOUT_CYCLES = 400;
	localparam int          CASES_DEPTH    = 512;
	localparam int          FRAME_PIXELS   = IMAGE_WIDTH * IMAGE_HEIGHT;
	localparam string       CASES_FILE     = "verification/pool_cases.txt";
	localparam logic [31:0] LFSR_SEED      = 32'hdc430700;

	logic   clk;
	logic   reset;
	logic   stride2;
	logic   valid_in;
	pixel_t pxl_in;
	logic   valid_out;
	pixel_t pxl_out;

	// Frame count, then per frame: mode, inputs, output count, outputs
	logic [PIXEL_WIDTH-1:0] cases_mem [CASES_DEPTH];
	int                     cursor;
	logic [31:0]            lfsr_state;

	// Output pixels seen so far, oldest first
	pixel_t got_q [$];

	tb_clock_gen tb_clock_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	conv_pool_stride_top conv_pool_stride_top_i (
		.clk       (clk),
		.reset     (reset),
		.stride2   (stride2),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.valid_out (valid_out),
		.pxl_out   (pxl_out)
	);

	//////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////

	// Registered outputs are stable at the falling edge
	always @(negedge clk) begin
		if (valid_out === 1'b1) begin
			got_q.push_back(pxl_out);
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [PIXEL_WIDTH-1:0] expected,
		input logic [PIXEL_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s expected %h, actual %h",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic feedback;
		feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], feedback};
		return feedback;
	endfunction

	// 0 to 3 idle cycles, then one valid pixel
	task automatic send_pixel(input pixel_t value);
		int gap;
		gap    = 0;
		gap[1] = lfsr_bit();
		gap[0] = lfsr_bit();
		repeat (gap) begin
			@(negedge clk);
			valid_in = 1'b0;
		end
		@(negedge clk);
		valid_in = 1'b1;
		pxl_in   = value;
	endtask

	task automatic wait_for_reset_release();
		int cycles;
		cycles = 0;
		while (reset !== 1'b0) begin
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("reset was never released after %0d cycles", cycles);
				abort_run();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic wait_for_outputs(input int count);
		int cycles;
		cycles = 0;
		while (got_q.size() < count) begin
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("an expected output never arrived: %0d of %0d pixels after %0d cycles",
					got_q.size(), count, cycles);
				abort_run();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	//////////////////////////////////////////////////
	// Frame runner
	//////////////////////////////////////////////////

	// Mode changes only while valid_in is low, between frames
	task automatic run_frame(input int frame);
		int count;
		stride2 = cases_mem[cursor][0];
		cursor++;
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			send_pixel(cases_mem[cursor]);
			cursor++;
		end
		@(negedge clk);
		valid_in = 1'b0;
		count = cases_mem[cursor];
		cursor++;
		wait_for_outputs(count);
		@(negedge clk);
		check_value($sformatf("valid_out count of frame %0d", frame), count, got_q.size());
		for (int i = 0; i < count; i++) begin
			check_value($sformatf("pxl_out frame %0d output %0d", frame, i),
				cases_mem[cursor], got_q.pop_front());
			cursor++;
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int frames;
		stride2    = 1'b0;
		valid_in   = 1'b0;
		pxl_in     = '0;
		lfsr_state = LFSR_SEED;
		cursor     = 0;
		$readmemh(CASES_FILE, cases_mem);
		if ($isunknown(cases_mem[0])) begin
			$display("the cases file could not be read");
			abort_run();
		end
		wait_for_reset_release();
		// DUT stays quiet until the first pixel
		repeat (8) @(negedge clk);
		check_value("valid_out count before first pixel", '0, got_q.size());
		frames = cases_mem[0];
		cursor = 1;
		for (int f = 0; f < frames; f++) begin
			run_frame(f);
		end
		repeat (8) @(negedge clk);
		check_value("valid_out count after last frame", '0, got_q.size());
		if (conv_pool_stride_top_i.conv_pool_stride_assert_i.failure_count != 0) begin
			$display("%0d concurrent assertion failures were reported",
				conv_pool_stride_top_i.conv_pool_stride_assert_i.failure_count);
			abort_run();
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

// File: verification/pool_cases.txt
// Word 0 is the frame count. Per frame, all hex: stride2 mode, 64 input pixels
// in raster order, expected output count, expected output pixels in order
3
// Frame 0, bypass
0
8000 8101 8202 8303 8404 8505 8606 8707
9010 9111 9212 9313 9414 9515 9616 9717
a020 a121 a222 a323 a424 a525 a626 a727
b030 b131 b232 b333 b434 b535 b636 b737
c040 c141 c242 c343 c444 c545 c646 c747
d050 d151 d252 d353 d454 d555 d656 d757
e060 e161 e262 e363 e464 e565 e666 e767
f070 f171 f272 f373 f474 f575 f676 f777
40
8000 8101 8202 8303 8404 8505 8606 8707
9010 9111 9212 9313 9414 9515 9616 9717
a020 a121 a222 a323 a424 a525 a626 a727
b030 b131 b232 b333 b434 b535 b636 b737
c040 c141 c242 c343 c444 c545 c646 c747
d050 d151 d252 d353 d454 d555 d656 d757
e060 e161 e262 e363 e464 e565 e666 e767
f070 f171 f272 f373 f474 f575 f676 f777
// Frame 1, stride 2 with the window maximum in a different corner per window
1
1000 0001 0002 1001 0004 0005 0006 0007
0010 0011 0012 0013 1002 0015 0016 1003
0020 1004 0022 0023 0024 0025 1007 0027
0030 0031 1005 0033 0034 1006 0036 0037
0040 0041 0042 0043 100a 0045 0046 100b
1008 0051 0052 1009 0054 0055 0056 0057
0060 0061 100d 0063 0064 100e 0066 0067
0070 100c 0072 0073 0074 0075 100f 0077
10
1000 1001 1002 1003 1004 1005 1006 1007
1008 1009 100a 100b 100c 100d 100e 100f
// Frame 2, stride 2 with all-negative and mixed-sign windows
1
8000 fffe 0001 ffff 7fff 8000 c000 c001
8001 ff00 8000 0000 ffff 0000 bfff c002
fff0 0010 8123 8124 ffff 0000 8000 8000
ffe0 0008 8122 8121 8000 fffe 8000 8000
0100 9000 ff80 ff7f 8001 0002 fffd fffc
a000 00ff ff81 fe00 0003 f003 fffb fffa
1234 edcb a5a5 9999 ffff 0001 8000 7ffe
8765 4321 b0b0 a000 fffe 8000 7fff ffff
10
fffe 0001 7fff c002 0010 8124 0000 8000
0100 ff81 0003 fffd 4321 b0b0 0001 7fff

// File: project.f
logic/pool_pkg.sv
logic/pixel_position_tracker.sv
logic/pool_window_buffer.sv
logic/stride2_output_align.sv
logic/conv_pool_stride_top.sv
verification/tb_clock_gen.sv
verification/conv_pool_stride_assert.sv
verification/conv_pool_stride_tb.sv

// File: Bender.yml
package:
  name: conv_pool_stride

dependencies: {}

sources:
  # Package first, then the RTL blocks and the top level
  - files:
      - logic/pool_pkg.sv
      - logic/pixel_position_tracker.sv
      - logic/pool_window_buffer.sv
      - logic/stride2_output_align.sv
      - logic/conv_pool_stride_top.sv

  # Testbench sources
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/conv_pool_stride_assert.sv
      - verification/conv_pool_stride_tb.sv
